//--- hw/gpu_pkg.sv
// Shared widths, state and opcode encodings for a single-thread core with 16 writable registers
`default_nettype none

package gpu_pkg;

    // Default widths, passed down from the top level as module parameters
    localparam int DATA_BITS      = 8;
    localparam int PROG_DATA_BITS = 16;
    localparam int ADDR_BITS      = 8;

    typedef enum logic [2:0] {
        IDLE    = 3'd0,
        FETCH   = 3'd1,
        DECODE  = 3'd2,
        REQUEST = 3'd3,
        WAIT    = 3'd4,
        EXECUTE = 3'd5,
        UPDATE  = 3'd6,
        DONE    = 3'd7
    } core_state_t;

    // Kept apart from the core state names on purpose
    typedef enum logic [1:0] {
        FETCHER_IDLE = 2'd0,
        FETCHING     = 2'd1,
        FETCHED      = 2'd2
    } fetcher_state_t;

    typedef enum logic [1:0] {
        LSU_IDLE       = 2'd0,
        LSU_REQUESTING = 2'd1,
        LSU_DONE       = 2'd2
    } lsu_state_t;

    // Instruction bits 15 to 12
    typedef enum logic [3:0] {
        NOP   = 4'd0,
        BRNZP = 4'd1,
        CMP   = 4'd2,
        ADD   = 4'd3,
        SUB   = 4'd4,
        MUL   = 4'd5,
        DIV   = 4'd6,
        LDR   = 4'd7,
        STR   = 4'd8,
        CONST = 4'd9,
        RET   = 4'd15
    } opcode_t;

endpackage

`default_nettype wire

//--- hw/mem_if.sv
// Memory buses hold valid and address until a one-cycle ready pulse, with read data in that cycle
`timescale 1ns/1ps
`default_nettype none

interface prog_mem_if #(
    parameter int ADDR_BITS = 8,
    parameter int DATA_BITS = 16
);
    logic                 read_valid;
    logic [ADDR_BITS-1:0] read_address;
    logic                 read_ready;
    logic [DATA_BITS-1:0] read_data;

    modport requester (output read_valid, read_address, input read_ready, read_data);
    modport memory (input read_valid, read_address, output read_ready, read_data);
endinterface

interface data_mem_if #(
    parameter int ADDR_BITS = 8,
    parameter int DATA_BITS = 8
);
    logic                 read_valid;
    logic [ADDR_BITS-1:0] read_address;
    logic                 read_ready;
    logic [DATA_BITS-1:0] read_data;
    // Write channel follows the same hold-until-ready rule
    logic                 write_valid;
    logic [ADDR_BITS-1:0] write_address;
    logic [DATA_BITS-1:0] write_data;
    logic                 write_ready;

    modport requester (
        output read_valid, read_address, write_valid, write_address, write_data,
        input  read_ready, read_data, write_ready
    );
    modport memory (
        input  read_valid, read_address, write_valid, write_address, write_data,
        output read_ready, read_data, write_ready
    );
endinterface

`default_nettype wire

//--- hw/core_scheduler.sv
// Multi-cycle sequencer with one instruction in flight; DONE is left only through reset
`timescale 1ns/1ps
`default_nettype none

module core_scheduler import gpu_pkg::*; #(
    parameter int ADDR_BITS = 8
) (
    input  wire                   clk,
    input  wire                   reset,
    input  wire                   start,
    input  fetcher_state_t        fetcher_state,
    input  lsu_state_t            lsu_state,
    input  opcode_t               opcode,
    input  wire [ADDR_BITS-1:0]   next_pc,
    output core_state_t           core_state,
    output logic [ADDR_BITS-1:0]  pc,
    output logic                  done
);

    logic mem_op;

    // Only loads and stores have to wait on the LSU
    assign mem_op = (opcode == LDR) || (opcode == STR);
    assign done   = (core_state == DONE);

    always_ff @(posedge clk) begin
        if (reset) begin
            core_state <= IDLE;
            pc         <= '0;
        end else begin
            case (core_state)
                IDLE: begin
                    if (start) begin
                        core_state <= FETCH;
                    end
                end
                FETCH: begin
                    // Length depends on program memory latency
                    if (fetcher_state == FETCHED) begin
                        core_state <= DECODE;
                    end
                end
                DECODE: begin
                    core_state <= REQUEST;
                end
                REQUEST: begin
                    core_state <= WAIT;
                end
                WAIT: begin
                    if (!mem_op || lsu_state == LSU_DONE) begin
                        core_state <= EXECUTE;
                    end
                end
                EXECUTE: begin
                    core_state <= UPDATE;
                end
                UPDATE: begin
                    pc <= next_pc;
                    if (opcode == RET) begin
                        core_state <= DONE;
                    end else begin
                        core_state <= FETCH;
                    end
                end
                DONE: begin
                    // Halted until reset
                    core_state <= DONE;
                end
                default: begin
                    core_state <= IDLE;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

//--- hw/fetcher.sv
// Reads one instruction per FETCH state; program memory must pulse ready once per request
`timescale 1ns/1ps
`default_nettype none

module fetcher import gpu_pkg::*; #(
    parameter int ADDR_BITS      = 8,
    parameter int PROG_DATA_BITS = 16
) (
    input  wire                       clk,
    input  wire                       reset,
    input  core_state_t               core_state,
    input  wire [ADDR_BITS-1:0]       pc,
    prog_mem_if.requester             prog,
    output fetcher_state_t            fetcher_state,
    output logic [PROG_DATA_BITS-1:0] instruction
);

    always_ff @(posedge clk) begin
        if (reset) begin
            fetcher_state   <= FETCHER_IDLE;
            prog.read_valid <= 1'b0;
        end else begin
            case (fetcher_state)
                FETCHER_IDLE: begin
                    if (core_state == FETCH) begin
                        fetcher_state     <= FETCHING;
                        prog.read_valid   <= 1'b1;
                        prog.read_address <= pc;
                    end
                end
                FETCHING: begin
                    // Valid and address stay put until the ready pulse
                    if (prog.read_ready) begin
                        fetcher_state   <= FETCHED;
                        instruction     <= prog.read_data;
                        prog.read_valid <= 1'b0;
                    end
                end
                FETCHED: begin
                    // Rearm once the decoder has taken the instruction
                    if (core_state == DECODE) begin
                        fetcher_state <= FETCHER_IDLE;
                    end
                end
                default: begin
                    fetcher_state <= FETCHER_IDLE;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

//--- hw/instr_decoder.sv
// Fields are sampled only in DECODE; opcodes outside the defined set decode as NOP
`timescale 1ns/1ps
`default_nettype none

module instr_decoder import gpu_pkg::*; (
    input  wire                       clk,
    input  wire                       reset,
    input  core_state_t               core_state,
    input  wire [PROG_DATA_BITS-1:0]  instruction,
    output opcode_t                   opcode,
    output logic [3:0]                rd,
    output logic [3:0]                rs,
    output logic [3:0]                rt,
    output logic [7:0]                imm,
    output logic [2:0]                nzp,
    output logic                      reg_write_enable
);

    opcode_t decoded_op;

    always_comb begin
        case (opcode_t'(instruction[15:12]))
            NOP, BRNZP, CMP, ADD, SUB, MUL, DIV, LDR, STR, CONST, RET:
                decoded_op = opcode_t'(instruction[15:12]);
            default:
                decoded_op = NOP;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            opcode           <= NOP;
            reg_write_enable <= 1'b0;
        end else if (core_state == DECODE) begin
            opcode           <= decoded_op;
            // Only these opcodes write rd back
            reg_write_enable <= decoded_op inside {ADD, SUB, MUL, DIV, LDR, CONST};
        end
    end

    always_ff @(posedge clk) begin
        if (core_state == DECODE) begin
            rd  <= instruction[11:8];
            rs  <= instruction[7:4];
            rt  <= instruction[3:0];
            imm <= instruction[7:0];
            nzp <= instruction[11:9];
        end
    end

endmodule

`default_nettype wire

//--- hw/exec_unit.sv
// Sixteen writable registers, arithmetic modulo 2**DATA_BITS, DIV by zero yields 0
`timescale 1ns/1ps
`default_nettype none

module exec_unit import gpu_pkg::*; #(
    parameter int DATA_BITS = 8,
    parameter int ADDR_BITS = 8
) (
    input  wire                   clk,
    input  wire                   reset,
    input  core_state_t           core_state,
    input  opcode_t               opcode,
    input  wire [3:0]             rd,
    input  wire [3:0]             rs,
    input  wire [3:0]             rt,
    input  wire [7:0]             imm,
    input  wire [2:0]             nzp,
    input  wire                   reg_write_enable,
    input  wire [ADDR_BITS-1:0]   pc,
    input  wire [DATA_BITS-1:0]   lsu_data,
    output logic [DATA_BITS-1:0]  rs_value,
    output logic [DATA_BITS-1:0]  rt_value,
    output logic [ADDR_BITS-1:0]  next_pc
);

    logic [DATA_BITS-1:0] regs [16];
    logic [DATA_BITS-1:0] alu_result;
    logic [DATA_BITS-1:0] alu_out;
    logic [2:0]           nzp_reg;
    logic signed [DATA_BITS:0] cmp_diff;

    assign rs_value = regs[rs];
    assign rt_value = regs[rt];

    // One extra bit keeps the signed difference free of overflow
    assign cmp_diff = $signed({rs_value[DATA_BITS-1], rs_value})
                    - $signed({rt_value[DATA_BITS-1], rt_value});

    always_comb begin
        case (opcode)
            ADD:     alu_result = rs_value + rt_value;
            SUB:     alu_result = rs_value - rt_value;
            MUL:     alu_result = rs_value * rt_value;
            DIV:     alu_result = (rt_value == '0) ? '0 : rs_value / rt_value;
            default: alu_result = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            nzp_reg <= 3'b000;
            for (int i = 0; i < 16; i++) begin
                regs[i] <= '0;
            end
        end else begin
            if (core_state == EXECUTE && opcode == CMP) begin
                nzp_reg <= {cmp_diff < 0, cmp_diff == 0, cmp_diff > 0};
            end
            if (core_state == UPDATE && reg_write_enable) begin
                case (opcode)
                    LDR:     regs[rd] <= lsu_data;
                    CONST:   regs[rd] <= DATA_BITS'(imm);
                    default: regs[rd] <= alu_out;
                endcase
            end
        end
    end

    always_ff @(posedge clk) begin
        if (core_state == EXECUTE) begin
            alu_out <= alu_result;
            // Branch compares against the flags left by an earlier CMP
            if (opcode == BRNZP && (nzp & nzp_reg) != 3'b000) begin
                next_pc <= ADDR_BITS'(imm);
            end else begin
                next_pc <= pc + ADDR_BITS'(1);
            end
        end
    end

endmodule

`default_nettype wire

//--- hw/lsu.sv
// Handles LDR and STR only, one access at a time; address comes from the rs register
`timescale 1ns/1ps
`default_nettype none

module lsu import gpu_pkg::*; #(
    parameter int DATA_BITS = 8,
    parameter int ADDR_BITS = 8
) (
    input  wire                   clk,
    input  wire                   reset,
    input  core_state_t           core_state,
    input  opcode_t               opcode,
    input  wire [DATA_BITS-1:0]   rs_value,
    input  wire [DATA_BITS-1:0]   rt_value,
    data_mem_if.requester         dmem,
    output lsu_state_t            lsu_state,
    output logic [DATA_BITS-1:0]  lsu_data
);

    always_ff @(posedge clk) begin
        if (reset) begin
            lsu_state        <= LSU_IDLE;
            dmem.read_valid  <= 1'b0;
            dmem.write_valid <= 1'b0;
        end else begin
            case (lsu_state)
                LSU_IDLE: begin
                    if (core_state == REQUEST && opcode == LDR) begin
                        lsu_state         <= LSU_REQUESTING;
                        dmem.read_valid   <= 1'b1;
                        dmem.read_address <= ADDR_BITS'(rs_value);
                    end else if (core_state == REQUEST && opcode == STR) begin
                        lsu_state          <= LSU_REQUESTING;
                        dmem.write_valid   <= 1'b1;
                        dmem.write_address <= ADDR_BITS'(rs_value);
                        dmem.write_data    <= rt_value;
                    end
                end
                LSU_REQUESTING: begin
                    // Whichever channel is open completes on its own ready
                    if (dmem.read_valid && dmem.read_ready) begin
                        lsu_state       <= LSU_DONE;
                        lsu_data        <= dmem.read_data;
                        dmem.read_valid <= 1'b0;
                    end else if (dmem.write_valid && dmem.write_ready) begin
                        lsu_state        <= LSU_DONE;
                        dmem.write_valid <= 1'b0;
                    end
                end
                LSU_DONE: begin
                    if (core_state == UPDATE) begin
                        lsu_state <= LSU_IDLE;
                    end
                end
                default: begin
                    lsu_state <= LSU_IDLE;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

//--- hw/core_top.sv
// Single-thread core; start is sampled in IDLE only and done stays high until reset
`timescale 1ns/1ps
`default_nettype none

module core_top import gpu_pkg::*; #(
    parameter int DATA_BITS      = gpu_pkg::DATA_BITS,
    parameter int ADDR_BITS      = gpu_pkg::ADDR_BITS,
    parameter int PROG_DATA_BITS = gpu_pkg::PROG_DATA_BITS
) (
    input  wire                       clk,
    input  wire                       reset,
    input  wire                       start,
    output logic                      done,
    // Program memory
    output logic                      prog_read_valid,
    output logic [ADDR_BITS-1:0]      prog_read_address,
    input  wire                       prog_read_ready,
    input  wire [PROG_DATA_BITS-1:0]  prog_read_data,
    // Data memory
    output logic                      data_read_valid,
    output logic [ADDR_BITS-1:0]      data_read_address,
    input  wire                       data_read_ready,
    input  wire [DATA_BITS-1:0]       data_read_data,
    output logic                      data_write_valid,
    output logic [ADDR_BITS-1:0]      data_write_address,
    output logic [DATA_BITS-1:0]      data_write_data,
    input  wire                       data_write_ready
);

    core_state_t          core_state;
    fetcher_state_t       fetcher_state;
    lsu_state_t           lsu_state;
    opcode_t              opcode;
    logic [ADDR_BITS-1:0] pc;
    logic [ADDR_BITS-1:0] next_pc;
    logic [PROG_DATA_BITS-1:0] instruction;
    logic [3:0]           rd;
    logic [3:0]           rs;
    logic [3:0]           rt;
    logic [7:0]           imm;
    logic [2:0]           nzp;
    logic                 reg_write_enable;
    logic [DATA_BITS-1:0] rs_value;
    logic [DATA_BITS-1:0] rt_value;
    logic [DATA_BITS-1:0] lsu_data;

    prog_mem_if #(.ADDR_BITS(ADDR_BITS), .DATA_BITS(PROG_DATA_BITS)) prog_bus ();
    data_mem_if #(.ADDR_BITS(ADDR_BITS), .DATA_BITS(DATA_BITS)) data_bus ();

    // Bus signals out to the plain memory ports
    assign prog_read_valid     = prog_bus.read_valid;
    assign prog_read_address   = prog_bus.read_address;
    assign prog_bus.read_ready = prog_read_ready;
    assign prog_bus.read_data  = prog_read_data;

    assign data_read_valid      = data_bus.read_valid;
    assign data_read_address    = data_bus.read_address;
    assign data_bus.read_ready  = data_read_ready;
    assign data_bus.read_data   = data_read_data;
    assign data_write_valid     = data_bus.write_valid;
    assign data_write_address   = data_bus.write_address;
    assign data_write_data      = data_bus.write_data;
    assign data_bus.write_ready = data_write_ready;

    core_scheduler #(.ADDR_BITS(ADDR_BITS)) u_scheduler (
        .clk           (clk),
        .reset         (reset),
        .start         (start),
        .fetcher_state (fetcher_state),
        .lsu_state     (lsu_state),
        .opcode        (opcode),
        .next_pc       (next_pc),
        .core_state    (core_state),
        .pc            (pc),
        .done          (done)
    );

    fetcher #(.ADDR_BITS(ADDR_BITS), .PROG_DATA_BITS(PROG_DATA_BITS)) u_fetcher (
        .clk           (clk),
        .reset         (reset),
        .core_state    (core_state),
        .pc            (pc),
        .prog          (prog_bus.requester),
        .fetcher_state (fetcher_state),
        .instruction   (instruction)
    );

    instr_decoder u_decoder (
        .clk              (clk),
        .reset            (reset),
        .core_state       (core_state),
        .instruction      (instruction),
        .opcode           (opcode),
        .rd               (rd),
        .rs               (rs),
        .rt               (rt),
        .imm              (imm),
        .nzp              (nzp),
        .reg_write_enable (reg_write_enable)
    );

    exec_unit #(.DATA_BITS(DATA_BITS), .ADDR_BITS(ADDR_BITS)) u_exec (
        .clk              (clk),
        .reset            (reset),
        .core_state       (core_state),
        .opcode           (opcode),
        .rd               (rd),
        .rs               (rs),
        .rt               (rt),
        .imm              (imm),
        .nzp              (nzp),
        .reg_write_enable (reg_write_enable),
        .pc               (pc),
        .lsu_data         (lsu_data),
        .rs_value         (rs_value),
        .rt_value         (rt_value),
        .next_pc          (next_pc)
    );

    lsu #(.DATA_BITS(DATA_BITS), .ADDR_BITS(ADDR_BITS)) u_lsu (
        .clk        (clk),
        .reset      (reset),
        .core_state (core_state),
        .opcode     (opcode),
        .rs_value   (rs_value),
        .rt_value   (rt_value),
        .dmem       (data_bus.requester),
        .lsu_state  (lsu_state),
        .lsu_data   (lsu_data)
    );

endmodule

`default_nettype wire

//--- testbench/tb_clock.sv
// Free-running 8 ns clock, reset held high for the first RESET_CYCLES rising edges
`timescale 1ns/1ps
`default_nettype none

module tb_clock #(
    parameter int RESET_CYCLES = 16
) (
    output logic clk,
    output logic reset
);

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    initial begin
        reset = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        reset = 1'b0;
    end

endmodule

`default_nettype wire

//--- testbench/core_tb.sv
// Directed core tests; memory models answer 1 to 4 cycles after valid and refill data on reset
`timescale 1ns/1ps
`default_nettype none

module core_tb import gpu_pkg::*; ();

    localparam logic [31:0] SEED = 32'h71ad701f;
    localparam int RESET_CYCLES   = 16;
    localparam int NUM_TESTS      = 4;
    localparam int TEST_BUDGET    = 200;
    // Reset, start pulse and the 20-cycle watch after done
    localparam int SETUP_CYCLES   = 50;
    localparam int TIMEOUT_CYCLES = (TEST_BUDGET + SETUP_CYCLES) * NUM_TESTS;
    localparam int MEM_WORDS      = 2 ** ADDR_BITS;

    logic clk;
    logic board_reset;
    logic test_reset = 1'b0;
    logic dut_reset;
    logic start = 1'b0;
    logic done;

    logic                      prog_read_valid;
    logic [ADDR_BITS-1:0]      prog_read_address;
    logic                      prog_read_ready = 1'b0;
    logic [PROG_DATA_BITS-1:0] prog_read_data = '0;
    logic                      data_read_valid;
    logic [ADDR_BITS-1:0]      data_read_address;
    logic                      data_read_ready = 1'b0;
    logic [DATA_BITS-1:0]      data_read_data = '0;
    logic                      data_write_valid;
    logic [ADDR_BITS-1:0]      data_write_address;
    logic [DATA_BITS-1:0]      data_write_data;
    logic                      data_write_ready = 1'b0;

    logic [PROG_DATA_BITS-1:0] prog_mem [MEM_WORDS];
    logic [DATA_BITS-1:0]      data_mem [MEM_WORDS];
    logic [ADDR_BITS-1:0]      load_addrs [$];
    logic [ADDR_BITS-1:0]      store_addrs [$];
    logic [DATA_BITS-1:0]      store_values [$];
    logic [31:0]               rng = SEED;
    int prog_left  = 0;
    int read_left  = 0;
    int write_left = 0;
    int prog_len   = 0;
    int cycle_count = 0;

    assign dut_reset = board_reset | test_reset;

    tb_clock #(.RESET_CYCLES(RESET_CYCLES)) clock_gen (
        .clk   (clk),
        .reset (board_reset)
    );

    core_top #(
        .DATA_BITS      (DATA_BITS),
        .ADDR_BITS      (ADDR_BITS),
        .PROG_DATA_BITS (PROG_DATA_BITS)
    ) DUT (
        .clk                (clk),
        .reset              (dut_reset),
        .start              (start),
        .done               (done),
        .prog_read_valid    (prog_read_valid),
        .prog_read_address  (prog_read_address),
        .prog_read_ready    (prog_read_ready),
        .prog_read_data     (prog_read_data),
        .data_read_valid    (data_read_valid),
        .data_read_address  (data_read_address),
        .data_read_ready    (data_read_ready),
        .data_read_data     (data_read_data),
        .data_write_valid   (data_write_valid),
        .data_write_address (data_write_address),
        .data_write_data    (data_write_data),
        .data_write_ready   (data_write_ready)
    );

    function automatic logic [31:0] lcg_step(input logic [31:0] state);
        return state * 32'd1664525 + 32'd1013904223;
    endfunction

    // Latency of 1 to 4 cycles from the upper LCG bits
    task automatic draw_latency(output int cycles);
        rng = lcg_step(rng);
        cycles = int'(rng[25:24]) + 1;
    endtask

    // All memory model state lives in this one process
    always @(posedge clk) begin
        logic in_reset;
        // Reset as the DUT sampled it on this edge
        in_reset = dut_reset;
        #1;
        prog_read_ready  = 1'b0;
        data_read_ready  = 1'b0;
        data_write_ready = 1'b0;
        if (in_reset) begin
            prog_left  = 0;
            read_left  = 0;
            write_left = 0;
            load_addrs.delete();
            store_addrs.delete();
            store_values.delete();
            for (int a = 0; a < MEM_WORDS; a++) begin
                rng = lcg_step(rng);
                data_mem[a] = rng[31:24];
            end
        end else begin
            if (prog_read_valid) begin
                if (prog_left == 0) begin
                    draw_latency(prog_left);
                end
                prog_left--;
                if (prog_left == 0) begin
                    prog_read_ready = 1'b1;
                    prog_read_data  = prog_mem[prog_read_address];
                end
            end
            if (data_read_valid) begin
                if (read_left == 0) begin
                    draw_latency(read_left);
                end
                read_left--;
                if (read_left == 0) begin
                    data_read_ready = 1'b1;
                    data_read_data  = data_mem[data_read_address];
                    load_addrs.push_back(data_read_address);
                end
            end
            if (data_write_valid) begin
                if (write_left == 0) begin
                    draw_latency(write_left);
                end
                write_left--;
                if (write_left == 0) begin
                    data_write_ready = 1'b1;
                    data_mem[data_write_address] = data_write_data;
                    store_addrs.push_back(data_write_address);
                    store_values.push_back(data_write_data);
                end
            end
        end
    end

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("Timeout after %0d cycles, the core did not finish its programs", cycle_count);
            stop_on_error();
        end
    end

    task automatic stop_on_error();
        $display("Testbench failed");
        $fatal(1);
    endtask

    task automatic check_byte(input string name, input logic [DATA_BITS-1:0] actual,
                              input logic [DATA_BITS-1:0] expected);
        if (actual !== expected) begin
            $display("ERROR %s: got 0x%h, expected 0x%h", name, actual, expected);
            stop_on_error();
        end
    endtask

    task automatic check_addr(input string name, input logic [ADDR_BITS-1:0] actual,
                              input logic [ADDR_BITS-1:0] expected);
        if (actual !== expected) begin
            $display("ERROR %s: got 0x%h, expected 0x%h", name, actual, expected);
            stop_on_error();
        end
    endtask

    task automatic expect_true(input logic condition, input string what);
        if (condition !== 1'b1) begin
            $display("Check failed: %s", what);
            stop_on_error();
        end
    endtask

    function automatic logic [15:0] enc_reg(input opcode_t op, input logic [3:0] rd,
                                            input logic [3:0] rs, input logic [3:0] rt);
        return {op, rd, rs, rt};
    endfunction

    function automatic logic [15:0] enc_imm(input opcode_t op, input logic [3:0] rd,
                                            input logic [7:0] imm);
        return {op, rd, imm};
    endfunction

    function automatic logic [15:0] enc_branch(input logic [2:0] nzp, input logic [7:0] target);
        return {BRNZP, nzp, 1'b0, target};
    endfunction

    // Unused words hold RET with the word address in the low byte
    task automatic clear_program();
        for (int a = 0; a < MEM_WORDS; a++) begin
            prog_mem[a] = {RET, 4'h0, 8'(a)};
        end
        prog_len = 0;
    endtask

    task automatic emit(input logic [15:0] word);
        prog_mem[prog_len] = word;
        prog_len++;
    endtask

    task automatic reset_core();
        @(posedge clk);
        #1;
        test_reset = 1'b1;
        start      = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        test_reset = 1'b0;
        @(posedge clk);
        #1;
        expect_true(done === 1'b0, "done is high after reset");
        expect_true(prog_read_valid === 1'b0, "program read valid is high after reset");
        expect_true(data_read_valid === 1'b0, "data read valid is high after reset");
        expect_true(data_write_valid === 1'b0, "data write valid is high after reset");
    endtask

    // Start, wait for done, then watch the halted core for 20 cycles
    task automatic run_program();
        int stores_at_done;
        @(posedge clk);
        #1;
        start = 1'b1;
        @(posedge clk);
        #1;
        start = 1'b0;
        while (done !== 1'b1) begin
            @(posedge clk);
            #1;
        end
        stores_at_done = store_addrs.size();
        repeat (20) begin
            @(posedge clk);
            #1;
            expect_true(done === 1'b1, "done dropped before reset");
            expect_true(prog_read_valid === 1'b0, "program read issued after RET");
            expect_true(data_write_valid === 1'b0, "data write issued after RET");
        end
        expect_true(store_addrs.size() == stores_at_done, "a store completed after RET");
    endtask

    task automatic test_arith();
        logic [DATA_BITS-1:0] a;
        logic [DATA_BITS-1:0] b;
        a = 8'd200;
        b = 8'd100;
        clear_program();
        emit(enc_imm(CONST, 4'd1, a));
        emit(enc_imm(CONST, 4'd2, b));
        emit(enc_reg(ADD, 4'd3, 4'd1, 4'd2));
        emit(enc_reg(SUB, 4'd4, 4'd2, 4'd1));
        emit(enc_reg(MUL, 4'd5, 4'd1, 4'd2));
        emit(enc_imm(CONST, 4'd6, 8'h10));
        emit(enc_reg(STR, 4'd0, 4'd6, 4'd3));
        emit(enc_imm(CONST, 4'd6, 8'h11));
        emit(enc_reg(STR, 4'd0, 4'd6, 4'd4));
        emit(enc_imm(CONST, 4'd6, 8'h12));
        emit(enc_reg(STR, 4'd0, 4'd6, 4'd5));
        emit(enc_reg(RET, 4'd0, 4'd0, 4'd0));
        reset_core();
        run_program();
        expect_true(store_addrs.size() == 3, "arithmetic program did not make three stores");
        check_addr("store 0 address", store_addrs[0], 8'h10);
        check_addr("store 1 address", store_addrs[1], 8'h11);
        check_addr("store 2 address", store_addrs[2], 8'h12);
        check_byte("data_mem[0x10] add", data_mem[8'h10], 8'((int'(a) + int'(b)) % 256));
        check_byte("data_mem[0x11] sub", data_mem[8'h11], 8'((int'(b) - int'(a) + 256) % 256));
        check_byte("data_mem[0x12] mul", data_mem[8'h12], 8'((int'(a) * int'(b)) % 256));
    endtask

    task automatic test_div();
        logic [DATA_BITS-1:0] a;
        logic [DATA_BITS-1:0] b;
        a = 8'd200;
        b = 8'd7;
        clear_program();
        emit(enc_imm(CONST, 4'd1, a));
        emit(enc_imm(CONST, 4'd2, b));
        emit(enc_reg(DIV, 4'd3, 4'd1, 4'd2));
        emit(enc_imm(CONST, 4'd4, 8'd0));
        // r5 starts nonzero, so the zero quotient has to be written
        emit(enc_imm(CONST, 4'd5, 8'hff));
        emit(enc_reg(DIV, 4'd5, 4'd1, 4'd4));
        emit(enc_imm(CONST, 4'd6, 8'h20));
        emit(enc_reg(STR, 4'd0, 4'd6, 4'd3));
        emit(enc_imm(CONST, 4'd6, 8'h21));
        emit(enc_reg(STR, 4'd0, 4'd6, 4'd5));
        emit(enc_reg(RET, 4'd0, 4'd0, 4'd0));
        reset_core();
        run_program();
        expect_true(store_addrs.size() == 2, "divide program did not make two stores");
        check_addr("store 0 address", store_addrs[0], 8'h20);
        check_addr("store 1 address", store_addrs[1], 8'h21);
        check_byte("data_mem[0x20] quotient", data_mem[8'h20], 8'(int'(a) / int'(b)));
        check_byte("data_mem[0x21] divide by zero", data_mem[8'h21], 8'd0);
    endtask

    // Counts 5 down to 1, storing each count at 0x30 plus the count
    task automatic test_loop();
        logic [DATA_BITS-1:0] count;
        logic [ADDR_BITS-1:0] exp_addr [$];
        logic [DATA_BITS-1:0] exp_val [$];
        clear_program();
        emit(enc_imm(CONST, 4'd1, 8'd5));
        emit(enc_imm(CONST, 4'd2, 8'd1));
        emit(enc_imm(CONST, 4'd3, 8'd0));
        emit(enc_imm(CONST, 4'd4, 8'h30));
        emit(enc_reg(ADD, 4'd5, 4'd4, 4'd1));
        emit(enc_reg(STR, 4'd0, 4'd5, 4'd1));
        emit(enc_reg(SUB, 4'd1, 4'd1, 4'd2));
        emit(enc_reg(CMP, 4'd0, 4'd1, 4'd3));
        emit(enc_branch(3'b001, 8'd4));
        emit(enc_reg(RET, 4'd0, 4'd0, 4'd0));
        reset_core();
        run_program();
        // Branch back while count minus one is positive as a signed byte
        count = 8'd5;
        do begin
            exp_addr.push_back(8'h30 + count);
            exp_val.push_back(count);
            count = count - 8'd1;
        end while ($signed(count) > 0);
        expect_true(store_addrs.size() == exp_addr.size(), "loop made the wrong number of stores");
        foreach (exp_addr[i]) begin
            check_addr($sformatf("loop store %0d address", i), store_addrs[i], exp_addr[i]);
            check_byte($sformatf("loop store %0d data", i), store_values[i], exp_val[i]);
        end
    endtask

    task automatic test_load_add();
        logic [DATA_BITS-1:0] x;
        logic [DATA_BITS-1:0] y;
        clear_program();
        emit(enc_imm(CONST, 4'd1, 8'h40));
        emit(enc_imm(CONST, 4'd2, 8'h41));
        emit(enc_reg(LDR, 4'd3, 4'd1, 4'd0));
        emit(enc_reg(LDR, 4'd4, 4'd2, 4'd0));
        emit(enc_reg(ADD, 4'd5, 4'd3, 4'd4));
        emit(enc_imm(CONST, 4'd6, 8'h50));
        emit(enc_reg(STR, 4'd0, 4'd6, 4'd5));
        emit(enc_reg(RET, 4'd0, 4'd0, 4'd0));
        reset_core();
        x = data_mem[8'h40];
        y = data_mem[8'h41];
        run_program();
        expect_true(load_addrs.size() == 2, "load program did not make two loads");
        check_addr("load 0 address", load_addrs[0], 8'h40);
        check_addr("load 1 address", load_addrs[1], 8'h41);
        expect_true(store_addrs.size() == 1, "load program did not make one store");
        check_addr("load store address", store_addrs[0], 8'h50);
        check_byte("data_mem[0x50] loaded sum", data_mem[8'h50], 8'((int'(x) + int'(y)) % 256));
    endtask

    initial begin
        wait (board_reset === 1'b0);
        test_arith();
        test_div();
        test_loop();
        test_load_add();
        $display("Testbench passed");
        $finish;
    end

endmodule

`default_nettype wire

//--- list.f
hw/gpu_pkg.sv
hw/mem_if.sv
hw/core_scheduler.sv
hw/fetcher.sv
hw/instr_decoder.sv
hw/exec_unit.sv
hw/lsu.sv
hw/core_top.sv
testbench/tb_clock.sv
testbench/core_tb.sv

//--- run.sh
#!/bin/sh
# Build the core testbench with Verilator, run it and judge the log
cd "$(dirname "$0")" || exit 1
LOG=sim.log

if ! verilator --binary --timing -f list.f --top-module core_tb -o core_sim; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/core_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ "$status" -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "Testbench passed" "$LOG"; then
    exit 0
else
    echo "Pass message not found in $LOG"
    exit 1
fi
